// ==== files.f ====
source/DaqTimingPkg.sv
source/DaqStatePkg.sv
source/AsicSyncIf.sv
source/AsicInputSync.sv
source/AcqSequencer.sv
source/DaqControlTop.sv
tb/DaqControlTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DAQ controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 -Wno-fatal --top-module DaqControlTb -f files.f -o simDaq \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/simDaq > sim.log 2>&1
cat sim.log
# Pass only when the testbench reported it
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/DaqControlTb.sv ====
`timescale 1ns/1ps

module DaqControlTb;

    import DaqTimingPkg::*;

    // One acquisition cycle of the session
    typedef struct {
        int acqTime;        // AcquisitionTime
        int holdTime;       // EndHoldTime
        bit satEarly;       // Chip fills up inside the window
        int satAt;          // Window cycle where the chip saturates
        int minWidth;       // StartAcq width bounds
        int maxWidth;
    } CycleRow_t;

    localparam int RowCount = 6;

    logic Clk;
    logic reset_n;
    logic ModuleStart;
    logic AcqStart;
    logic EndReadout;
    logic ChipSatB;
    logic DataTransmitDone;
    logic [CountWidth-1:0] AcquisitionTime;
    logic [CountWidth-1:0] EndHoldTime;
    logic ResetB;
    logic StartAcq;
    logic StartReadout;
    logic PwrOnA;
    logic PwrOnD;
    logic PwrOnDac;
    logic OnceEnd;
    logic AllDone;

    CycleRow_t rows [RowCount];
    bit sessionActive;      // Power rails must stay up while set
    int resetLow;

    DaqControlTop dut (.*);

    always #4 Clk = ~Clk;   // 125 MHz

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic checkEq(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("ERR at %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge Clk);
    endtask

    // Every output at its reset level and power rails off
    task automatic checkIdleOutputs(input string when);
        checkEq(int'(ResetB), 1, {when, ": ResetB"});
        checkEq(int'(StartAcq), 0, {when, ": StartAcq"});
        checkEq(int'(StartReadout), 0, {when, ": StartReadout"});
        checkEq(int'(OnceEnd), 0, {when, ": OnceEnd"});
        checkEq(int'(AllDone), 0, {when, ": AllDone"});
        checkEq(int'(PwrOnA), 0, {when, ": PwrOnA"});
        checkEq(int'(PwrOnD), 0, {when, ": PwrOnD"});
        checkEq(int'(PwrOnDac), 0, {when, ": PwrOnDac"});
    endtask

    // Digital rail never ahead of analogue and DAC
    task automatic checkPowerOrder();
        checkEq(int'(PwrOnA || !PwrOnD), 1, "PwrOnD high before PwrOnA");
        checkEq(int'(PwrOnDac || !PwrOnD), 1, "PwrOnD high before PwrOnDac");
    endtask

    // Width is acqTime+1 without saturation and ends within 3 cycles of satAt with it
    task automatic loadTable();
        rows[0] = '{20, 4, 1'b0, 0, 21, 21};
        rows[1] = '{12, 0, 1'b0, 0, 13, 13};
        rows[2] = '{40, 7, 1'b1, 5, 6, 8};
        rows[3] = '{3, 2, 1'b0, 0, 4, 4};
        rows[4] = '{60, 10, 1'b1, 10, 11, 13};
        rows[5] = '{0, 1, 1'b0, 0, 1, 1};        // Shortest window
    endtask

    function automatic int timeoutCycles();
        int total;
        total = 10 + 6 + int'(TimeMinPowerReset) + int'(TimeMinResetStart) + 30;  // Startup
        for (int r = 0; r < RowCount; r++) begin
            // Window, strobes, hold, plus trigger gap and chip delays
            total += rows[r].acqTime + rows[r].holdTime + int'(TimeMinSro) + 50;
        end
        total += 20;            // Session end
        return 2 * total;
    endfunction

    //////////////////////////////////////////////////
    // One acquisition cycle with the chip model
    //////////////////////////////////////////////////
    task automatic runCycle(input CycleRow_t row, input int idx);
        int width;
        int cycle;
        int satCycle;
        width = 0;
        cycle = 0;
        satCycle = 0;
        @(posedge Clk);
        AcquisitionTime <= CountWidth'(row.acqTime);
        EndHoldTime     <= CountWidth'(row.holdTime);
        waitCycles(1 + int'($urandom % 8));    // Random trigger gap
        AcqStart <= 1'b1;
        waitCycles(2);
        AcqStart <= 1'b0;
        @(negedge Clk);
        while (StartAcq !== 1'b1) @(negedge Clk);
        while (StartAcq === 1'b1) begin        // Window width with the chip filling up on request
            width++;
            @(posedge Clk);
            cycle++;
            if (row.satEarly && width == row.satAt) begin
                ChipSatB <= 1'b0;               // Chip full
                satCycle = cycle;
            end
            @(negedge Clk);
        end
        checkEq(int'(width >= row.minWidth && width <= row.maxWidth), 1,
            $sformatf("row %0d StartAcq width %0d out of bounds", idx, width));
        if (row.satEarly) begin
            checkEq(int'(cycle - satCycle <= 3), 1, "StartAcq late after ChipSatB fell");
            checkEq(int'(width < row.acqTime + 1), 1, "Saturated window not shortened");
        end
        // Chip drops saturation if it did not, then releases it later
        @(posedge Clk);
        ChipSatB <= 1'b0;
        waitCycles(2 + int'($urandom % 8));
        ChipSatB <= 1'b1;
        width = 0;
        @(negedge Clk);
        while (StartReadout !== 1'b1) @(negedge Clk);
        while (StartReadout === 1'b1) begin
            width++;
            @(negedge Clk);
        end
        checkEq(width, int'(TimeMinSro) + 1, $sformatf("row %0d StartReadout width", idx));
        // RAM readout takes a random time
        waitCycles(1 + int'($urandom % 10));
        EndReadout <= 1'b1;
        width = 0;
        @(negedge Clk);
        while (OnceEnd !== 1'b1) @(negedge Clk);
        while (OnceEnd === 1'b1) begin
            width++;
            @(posedge Clk);
            EndReadout <= 1'b0;                 // Flag cleared once seen
            @(negedge Clk);
        end
        checkEq(width, row.holdTime + 1, $sformatf("row %0d OnceEnd width", idx));
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(69086));
        Clk = 1'b0;
        reset_n = 1'b0;
        ModuleStart = 1'b0;
        AcqStart = 1'b0;
        EndReadout = 1'b0;
        ChipSatB = 1'b1;                        // Not saturated
        DataTransmitDone = 1'b0;
        AcquisitionTime = '0;
        EndHoldTime = '0;
        sessionActive = 1'b0;
        loadTable();
        @(negedge Clk);
        checkIdleOutputs("During reset");
        waitCycles(10);
        reset_n <= 1'b1;
        repeat (6) begin
            @(negedge Clk);
            checkIdleOutputs("Idle after reset");
        end

        // Startup with ResetB pulse and power order
        @(posedge Clk);
        ModuleStart <= 1'b1;
        resetLow = 0;
        @(negedge Clk);
        while (ResetB !== 1'b0) begin
            checkPowerOrder();
            @(negedge Clk);
        end
        while (ResetB === 1'b0) begin
            checkPowerOrder();
            resetLow++;
            @(negedge Clk);
        end
        checkEq(int'(resetLow >= int'(TimeMinPowerReset) + 2), 1, "ResetB low too short");
        sessionActive = 1'b1;

        // Trigger inside Release must be ignored
        @(posedge Clk);
        AcqStart <= 1'b1;
        waitCycles(2);
        AcqStart <= 1'b0;
        repeat (int'(TimeMinResetStart) + 2) begin
            @(negedge Clk);
            checkEq(int'(StartAcq), 0, "StartAcq rose on a trigger during Release");
        end

        for (int r = 0; r < RowCount; r++) begin
            runCycle(rows[r], r);
        end

        // Session end
        @(posedge Clk);
        ModuleStart <= 1'b0;
        sessionActive = 1'b0;
        repeat (2) @(negedge Clk);
        checkEq(int'(AllDone), 1, "AllDone not set after ModuleStart fell");
        checkEq(int'(PwrOnA), 0, "PwrOnA still high at session end");
        checkEq(int'(PwrOnD), 0, "PwrOnD still high at session end");
        checkEq(int'(PwrOnDac), 0, "PwrOnDac still high at session end");
        repeat (4) begin
            @(negedge Clk);
            checkEq(int'(AllDone), 1, "AllDone dropped before DataTransmitDone");
        end
        @(posedge Clk);
        DataTransmitDone <= 1'b1;
        @(posedge Clk);
        DataTransmitDone <= 1'b0;
        @(negedge Clk);
        checkEq(int'(AllDone), 0, "AllDone not cleared after DataTransmitDone");
        checkIdleOutputs("Back in Idle");
        $display("Simulation passed");
        $finish;
    end

    // Power rails stay up through the whole session
    always @(negedge Clk) begin
        if (sessionActive) begin
            checkEq(int'(PwrOnA), 1, "PwrOnA low during the session");
            checkEq(int'(PwrOnD), 1, "PwrOnD low during the session");
            checkEq(int'(PwrOnDac), 1, "PwrOnDac low during the session");
        end
    end

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////
    initial begin
        int limit;
        #1;
        limit = timeoutCycles();
        repeat (limit) @(posedge Clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Simulation failed");
        $fatal(1);
    end

endmodule

// ==== source/DaqControlTop.sv ====
`timescale 1ns/1ps

module DaqControlTop (
    input  logic Clk,
    input  logic reset_n,
    input  logic ModuleStart,                                   // From host
    input  logic AcqStart,                                      // External trigger
    input  logic EndReadout,                                    // From chip
    input  logic ChipSatB,                                      // From chip, active low
    input  logic [DaqTimingPkg::CountWidth-1:0] AcquisitionTime, // From host
    input  logic [DaqTimingPkg::CountWidth-1:0] EndHoldTime,    // From host
    input  logic DataTransmitDone,                              // From host
    output logic ResetB,
    output logic StartAcq,
    output logic StartReadout,
    output logic PwrOnA,
    output logic PwrOnD,
    output logic PwrOnDac,
    output logic OnceEnd,
    output logic AllDone
);

    //////////////////////////////////////////////////
    // Synchronized chip events
    //////////////////////////////////////////////////
    AsicSyncIf syncEvents ();

    // Async pins into the Clk domain
    AsicInputSync inputSync (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .AcqStart   (AcqStart),
        .ChipSatB   (ChipSatB),
        .EndReadout (EndReadout),
        .Events     (syncEvents.Source)
    );

    //////////////////////////////////////////////////
    // Acquisition sequencer
    //////////////////////////////////////////////////
    AcqSequencer sequencer (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .ModuleStart      (ModuleStart),
        .DataTransmitDone (DataTransmitDone),
        .AcquisitionTime  (AcquisitionTime),
        .EndHoldTime      (EndHoldTime),
        .Events           (syncEvents.Sink),
        .ResetB           (ResetB),
        .StartAcq         (StartAcq),
        .StartReadout     (StartReadout),
        .OnceEnd          (OnceEnd),
        .AllDone          (AllDone),
        .PwrOnA           (PwrOnA),
        .PwrOnD           (PwrOnD),
        .PwrOnDac         (PwrOnDac)
    );

endmodule

// ==== source/AcqSequencer.sv ====
`timescale 1ns/1ps

module AcqSequencer (
    input  logic Clk,
    input  logic reset_n,
    input  logic ModuleStart,                                   // Host session level
    input  logic DataTransmitDone,                              // Host finished transfer
    input  logic [DaqTimingPkg::CountWidth-1:0] AcquisitionTime, // Window length - 1
    input  logic [DaqTimingPkg::CountWidth-1:0] EndHoldTime,    // OnceEnd hold - 1
    AsicSyncIf.Sink Events,
    output logic ResetB,            // Chip digital reset, active low
    output logic StartAcq,          // Acquisition window
    output logic StartReadout,      // Chip RAM readout start
    output logic OnceEnd,           // End of one acquisition cycle
    output logic AllDone,           // Session finished
    output logic PwrOnA,            // Analogue power pulsing
    output logic PwrOnD,            // Digital power pulsing
    output logic PwrOnDac           // DAC power pulsing
);

    import DaqTimingPkg::*;
    import DaqStatePkg::*;

    DaqState_t State;
    DaqState_t NextState;
    logic [CountWidth-1:0] DelayCount;  // Shared delay counter
    logic StateChange;

    //////////////////////////////////////////////////
    // Next state decode
    //////////////////////////////////////////////////
    always_comb begin
        NextState = State;      // Hold by default
        unique case (State)
            Idle: begin
                if (ModuleStart) begin
                    NextState = ChipReset;     // Session begins
                end
            end
            ChipReset: begin
                NextState = PowerOn;           // Single cycle
            end
            PowerOn: begin
                if (DelayCount >= TimeMinPowerReset) begin
                    NextState = Release;
                end
            end
            Release: begin
                if (DelayCount >= TimeMinResetStart) begin
                    NextState = WaitStart;     // Acquisition enabled from here
                end
            end
            WaitStart: begin
                // Session end wins over a trigger on the same cycle
                if (!ModuleStart) begin
                    NextState = AllDoneWait;
                end else if (Events.TrigRise) begin
                    NextState = Acquire;
                end
            end
            Acquire: begin
                // Window closes on timeout or when the chip is full
                if (DelayCount >= AcquisitionTime || Events.ChipFull) begin
                    NextState = WaitRead;
                end
            end
            WaitRead: begin
                if (Events.ReadStart) begin
                    NextState = StartRead;
                end
            end
            StartRead: begin
                if (DelayCount >= TimeMinSro) begin
                    NextState = WaitReadDone;
                end
            end
            WaitReadDone: begin
                if (Events.EndReadoutLvl) begin
                    NextState = OnceEndHold;
                end
            end
            OnceEndHold: begin
                if (DelayCount >= EndHoldTime) begin
                    NextState = WaitStart;     // Rearm for the next trigger
                end
            end
            AllDoneWait: begin
                if (DataTransmitDone) begin
                    NextState = Idle;          // Stays here until released
                end
            end
            default: begin
                NextState = Idle;              // Recover from illegal codes
            end
        endcase
    end

    assign StateChange = (NextState != State);

    //////////////////////////////////////////////////
    // State register and delay counter
    //////////////////////////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State      <= Idle;
            DelayCount <= '0;
        end else begin
            State <= NextState;
            if (StateChange) begin
                DelayCount <= '0;                   // Every phase counts from zero
            end else begin
                DelayCount <= DelayCount + 1'b1;    // Wraps harmlessly in wait states
            end
        end
    end

    //////////////////////////////////////////////////
    // Registered outputs, decoded from next state
    //////////////////////////////////////////////////
    // Each output moves on the same edge as the state
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            ResetB       <= 1'b1;
            StartAcq     <= 1'b0;
            StartReadout <= 1'b0;
            OnceEnd      <= 1'b0;
            AllDone      <= 1'b0;
        end else begin
            // Digital reset held through ChipReset and PowerOn
            ResetB       <= !(NextState == ChipReset || NextState == PowerOn);
            StartAcq     <= (NextState == Acquire);
            StartReadout <= (NextState == StartRead);
            OnceEnd      <= (NextState == OnceEndHold);
            AllDone      <= (NextState == AllDoneWait);
        end
    end

    // Power pulsing follows the sequencer phase
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            PwrOnA   <= 1'b0;
            PwrOnD   <= 1'b0;
            PwrOnDac <= 1'b0;
        end else begin
            PwrOnA   <= (NextState >= PwrAFirst) && (NextState <= PwrLast);
            PwrOnDac <= (NextState >= PwrAFirst) && (NextState <= PwrLast);
            PwrOnD   <= (NextState >= PwrDFirst) && (NextState <= PwrLast);  // One phase later
        end
    end

endmodule

// ==== source/AsicInputSync.sv ====
`timescale 1ns/1ps

module AsicInputSync (
    input  logic Clk,
    input  logic reset_n,
    input  logic AcqStart,          // External trigger, async
    input  logic ChipSatB,          // Chip full, active low, async
    input  logic EndReadout,        // Chip RAM readout finished, async
    AsicSyncIf.Source Events
);

    import DaqTimingPkg::*;
    import DaqStatePkg::*;

    logic [PinCount-1:0] PinRaw;                     // Pins gathered into one vector
    logic [SyncStages-1:0][PinCount-1:0] PinSync;    // Synchronizer chain, [0] first
    logic [PinCount-1:0] PinStable;                  // Last stage, safe to use
    logic [PinCount-1:0] PinPrev;                    // One cycle older, for edges

    //////////////////////////////////////////////////
    // Two-stage synchronizers, all three pins
    //////////////////////////////////////////////////
    always_comb begin
        PinRaw = '0;
        PinRaw[PinTrig] = AcqStart;
        PinRaw[PinSat]  = ChipSatB;
        PinRaw[PinEnd]  = EndReadout;
    end

    // Reset to idle pin levels so no false edge shows after reset
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            PinSync <= {SyncStages{PinIdle}};
            PinPrev <= PinIdle;
        end else begin
            PinSync[0] <= PinRaw;
            for (int i = 1; i < SyncStages; i++) begin
                PinSync[i] <= PinSync[i-1];   // Shift down the chain
            end
            PinPrev <= PinSync[SyncStages-1];
        end
    end

    assign PinStable = PinSync[SyncStages-1];

    //////////////////////////////////////////////////
    // Edge detection
    //////////////////////////////////////////////////
    // Trigger rising edge starts a window
    assign Events.TrigRise = PinStable[PinTrig] & ~PinPrev[PinTrig];

    // Saturation falling edge, one or more chips full
    assign Events.ChipFull = ~PinStable[PinSat] & PinPrev[PinSat];

    // Saturation rising edge, chip ready for readout
    assign Events.ReadStart = PinStable[PinSat] & ~PinPrev[PinSat];

    assign Events.EndReadoutLvl = PinStable[PinEnd];    // Passed on as a level

endmodule

// ==== source/AsicSyncIf.sv ====
`timescale 1ns/1ps

// Synchronized chip and trigger events, single-cycle pulses and one level
interface AsicSyncIf;

    logic TrigRise;         // Trigger rising edge
    logic ChipFull;         // Saturation falling edge, chip is full
    logic ReadStart;        // Saturation rising edge, readout may start
    logic EndReadoutLvl;    // End of readout, synchronized level

    modport Source (
        output TrigRise, ChipFull, ReadStart, EndReadoutLvl
    );

    modport Sink (
        input TrigRise, ChipFull, ReadStart, EndReadoutLvl
    );

endinterface

// ==== source/DaqStatePkg.sv ====
package DaqStatePkg;

    // Sequencer phases, order matters for the power range decode
    typedef enum logic [3:0] {
        Idle,                   // Waiting for ModuleStart
        ChipReset,              // Digital reset asserted, analogue power up
        PowerOn,                // Digital power up, reset still held
        Release,                // Reset released, chip settling
        WaitStart,              // Armed, waiting for a trigger edge
        Acquire,                // Acquisition window open
        WaitRead,               // Waiting for the chip to release saturation
        StartRead,              // Readout start strobe held
        WaitReadDone,           // Chip reading out its RAM
        OnceEndHold,            // End of one cycle flag held
        AllDoneWait             // Session over, waiting for host transfer
    } DaqState_t;

    // Power pulsing ranges over the state order
    localparam DaqState_t PwrAFirst = ChipReset;    // Analogue and DAC rails
    localparam DaqState_t PwrDFirst = PowerOn;      // Digital rail
    localparam DaqState_t PwrLast   = OnceEndHold;  // Last powered phase

    // Async pin slots in the synchronizer vector and their idle levels
    localparam int PinCount = 3;
    localparam int PinTrig  = 0;        // External trigger, idle low
    localparam int PinSat   = 1;        // Chip saturation, active low, idle high
    localparam int PinEnd   = 2;        // End of readout, idle low
    localparam logic [PinCount-1:0] PinIdle = 3'b010;

endpackage

// ==== source/DaqTimingPkg.sv ====
package DaqTimingPkg;

    //////////////////////////////////////////////////
    // Counter and synchronizer sizing
    //////////////////////////////////////////////////
    localparam int CountWidth = 16;         // Delay counter and host times
    localparam int SyncStages = 2;          // Flip-flops per async pin

    //////////////////////////////////////////////////
    // Fixed sequencer delays, in Clk cycles
    //////////////////////////////////////////////////
    // Power-on reset hold, wakes the LVDS clock receivers
    localparam logic [CountWidth-1:0] TimeMinPowerReset = CountWidth'(8);
    // Reset release to acquisition enable, covers internal chip management
    localparam logic [CountWidth-1:0] TimeMinResetStart = CountWidth'(40);
    // Extra hold of the readout start strobe
    localparam logic [CountWidth-1:0] TimeMinSro = CountWidth'(16);

endpackage
